/* filelist.f */
isa_pkg.sv
fetch_pkg.sv
full_predecode.sv
compressed_predecode.sv
fetch_unit.sv
fetch_top.sv
tb_fetch_top.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing
TOP       = tb_fetch_top
FILELIST  = filelist.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb_fetch_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_fetch_top
    import fetch_pkg::*;
    import isa_pkg::*;
;

    localparam addr_t start_pc        = 32'h0000_0000;
    localparam int    queue_depth     = 16;
    localparam int    expected_instrs = 40;
    localparam int    cycle_limit     = 40 * expected_instrs + 200;

    logic        clk;
    logic        rst;
    logic        stall;
    logic        redirect;
    addr_t       redirect_pc;
    logic        retire;
    logic        mem_req;
    addr_t       mem_addr;
    logic        mem_valid = 1'b0;
    instr_word_t mem_data = '0;
    logic        instr_valid;
    instr_word_t instr;
    addr_t       instr_pc;
    addr_t       retire_pc;

    // sparse program memory, one entry per halfword
    logic [15:0] mem_h [addr_t];

    integer seed = 32'h8ff3_5fd4;
    int     cycles = 0;
    int     delivered = 0;

    // memory model state
    logic   busy = 1'b0;
    logic   answer = 1'b0;
    addr_t  req_addr;
    int     delay;

    // expected state
    addr_t  exp_pc = start_pc;
    logic   exp_stop = 1'b0;
    addr_t  exp_retire = start_pc;
    addr_t  pc_q [$];
    addr_t  step_q [$];

    fetch_top #(
        .reset_pc        (start_pc),
        .len_queue_depth (queue_depth)
    ) fetch_top_i (
        .clk         (clk),
        .rst         (rst),
        .stall       (stall),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .retire      (retire),
        .mem_req     (mem_req),
        .mem_addr    (mem_addr),
        .mem_valid   (mem_valid),
        .mem_data    (mem_data),
        .instr_valid (instr_valid),
        .instr       (instr),
        .instr_pc    (instr_pc),
        .retire_pc   (retire_pc)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("CHECKS FAILED");
        $fatal(1, "stopping after first error");
    endtask

    task automatic check_addr(input string name, input addr_t act, input addr_t exp);
        if (act !== exp) begin
            $display("** Error at %0t: %s = %h, expected %h", $time, name, act, exp);
            fail_run("address mismatch");
        end
    endtask

    task automatic check_instr(input string name, input instr_word_t act,
                               input instr_word_t exp);
        if (act.full !== exp.full) begin
            $display("** Error at %0t: %s = %h, expected %h", $time, name, act.full,
                     exp.full);
            fail_run("instruction mismatch");
        end
    endtask

    function automatic logic [15:0] read_half(input addr_t a);
        logic [15:0] folded;
        // unwritten memory reads as quadrant 0 parcels, none of which change control flow
        folded = a[31:16] ^ a[15:0];
        if (mem_h.exists(a)) begin
            return mem_h[a];
        end
        return {folded[15:2] ^ {12'd0, folded[1:0]}, 2'b00};
    endfunction

    function automatic instr_word_t read_word(input addr_t a);
        instr_word_t w;
        w.full = {read_half(a + 32'd2), read_half(a)};
        return w;
    endfunction

    task automatic put_half(input addr_t a, input logic [15:0] h);
        mem_h[a] = h;
    endtask

    task automatic put_word(input addr_t a, input logic [31:0] w);
        mem_h[a]         = w[15:0];
        mem_h[a + 32'd2] = w[31:16];
    endtask

    function automatic logic [31:0] j_enc(input addr_t off);
        return {off[20], off[10:1], off[11], off[19:12], 5'd0, 7'h6f};
    endfunction

    function automatic logic [15:0] cj_enc(input logic [2:0] funct3, input addr_t off);
        return {funct3, off[11], off[4], off[9:8], off[10], off[6], off[7], off[3:1],
                off[5], 2'b01};
    endfunction

    // next pc and stop that the fetch stage should predict after one instruction
    function automatic addr_t expected_next(input addr_t pc, input instr_word_t w,
                                            output logic stop);
        logic [20:0] imm21;
        logic [11:0] imm12;
        logic [15:0] c;
        c    = w.full[15:0];
        stop = 1'b0;
        if (w.full[1:0] == 2'b11) begin
            imm21 = {w.full[31], w.full[19:12], w.full[20], w.full[30:21], 1'b0};
            if (w.full[6:0] == 7'h6f) begin
                return pc + {{11{imm21[20]}}, imm21};
            end
            if (w.full[6:0] == 7'h67) begin
                stop = 1'b1;
            end
            return pc + 32'd4;
        end
        imm12 = {c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3], 1'b0};
        if (c[1:0] == 2'b01 && (c[15:13] == 3'b101 || c[15:13] == 3'b001)) begin
            return pc + {{20{imm12[11]}}, imm12};
        end
        if (c[1:0] == 2'b10 && c[15:13] == 3'b100 && c[11:7] != 5'd0 && c[6:2] == 5'd0) begin
            stop = 1'b1;
        end
        return pc + 32'd2;
    endfunction

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            fail_run("timeout: the fetch stage stopped delivering instructions");
        end
    end

    // memory takes a request at the rising edge and answers on a later falling edge
    always @(posedge clk) begin
        answer = 1'b0;
        if (!rst && mem_req) begin
            if (busy) begin
                fail_run("second memory request while one is outstanding");
            end
            busy     = 1'b1;
            req_addr = mem_addr;
            delay    = 1 + int'($unsigned($random(seed)) % 32'd4);
        end
        if (busy) begin
            delay = delay - 1;
            if (delay == 0) begin
                answer = 1'b1;
                busy   = 1'b0;
            end
        end
    end

    always @(negedge clk) begin
        mem_valid = answer;
        if (answer) begin
            mem_data = read_word(req_addr);
        end
    end

    // compare process
    always @(posedge clk) begin
        addr_t       nxt;
        logic        stp;
        instr_word_t exp_word;
        int          q_size;
        if (!rst) begin
            q_size = pc_q.size();
            check_addr("retire_pc", retire_pc, exp_retire);
            if (stall && mem_req) begin
                fail_run("mem_req issued while stall is high");
            end
            if (exp_stop && mem_req) begin
                fail_run("mem_req issued after an indirect jump before redirect");
            end
            if (mem_req) begin
                check_addr("mem_addr", mem_addr, exp_pc);
            end
            if (retire && !redirect && q_size > 0) begin
                exp_retire = pc_q.pop_front() + step_q.pop_front();
            end
            if (instr_valid) begin
                exp_word = read_word(exp_pc);
                check_addr("instr_pc", instr_pc, exp_pc);
                check_instr("instr", instr, exp_word);
                nxt = expected_next(exp_pc, exp_word, stp);
                if (!redirect && q_size < queue_depth) begin
                    pc_q.push_back(exp_pc);
                    step_q.push_back((exp_word.full[1:0] == 2'b11) ? 32'd4 : 32'd2);
                end
                exp_pc    = nxt;
                exp_stop  = stp;
                delivered = delivered + 1;
            end
            if (redirect) begin
                exp_pc     = redirect_pc;
                exp_stop   = 1'b0;
                exp_retire = redirect_pc;
                pc_q.delete();
                step_q.delete();
            end
        end
    end

    task automatic wait_instrs(input int n);
        int target;
        target = delivered + n;
        while (delivered < target) begin
            @(negedge clk);
        end
    endtask

    task automatic idle(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic send_redirect(input addr_t pc);
        @(negedge clk);
        redirect    = 1'b1;
        redirect_pc = pc;
        @(negedge clk);
        redirect    = 1'b0;
    endtask

    task automatic pulse_retire();
        @(negedge clk);
        retire = 1'b1;
        @(negedge clk);
        retire = 1'b0;
    endtask

    task automatic load_program();
        addr_t a;
        put_word(32'h00, 32'h0010_0093);
        put_half(32'h04, 16'h0085);
        put_word(32'h06, 32'h0020_0113);
        put_half(32'h0a, 16'h0001);
        put_word(32'h0c, 32'h0000_0197);
        put_word(32'h10, 32'h0000_0463);
        put_word(32'h14, j_enc(32'h0000_0040));
        put_half(32'h54, cj_enc(3'b101, 32'hffff_ffe0));
        put_half(32'h34, cj_enc(3'b001, 32'h0000_0010));
        put_word(32'h44, j_enc(32'hffff_ffe0));
        put_word(32'h24, 32'h0000_8067);
        put_half(32'h100, 16'h0085);
        put_half(32'h102, 16'h8082);
        for (a = 32'h200; a < 32'h300; a = a + 32'd4) begin
            put_word(a, 32'h0000_0013);
        end
        // mixed lengths for retire tracking
        for (a = 32'h300; a < 32'h330; a = a + 32'd6) begin
            put_word(a, 32'h0000_0013);
            put_half(a + 32'd4, 16'h0001);
        end
    endtask

    initial begin
        rst         = 1'b1;
        stall       = 1'b0;
        redirect    = 1'b0;
        redirect_pc = '0;
        retire      = 1'b0;
        load_program();
        repeat (5) @(negedge clk);
        rst = 1'b0;

        // straight code, jumps both ways, ending on JALR
        wait_instrs(11);
        idle(10);
        send_redirect(32'h100);
        // C.JR stop
        wait_instrs(2);
        idle(10);
        send_redirect(32'h200);

        wait_instrs(3);
        @(negedge clk);
        stall = 1'b1;
        idle(20);
        stall = 1'b0;
        wait_instrs(3);

        // flush a request in flight
        @(posedge clk);
        while (!mem_req) begin
            @(posedge clk);
        end
        send_redirect(32'h300);

        repeat (10) begin
            wait_instrs(1);
            pulse_retire();
        end
        repeat (6) pulse_retire();
        idle(5);

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* fetch_top.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_top
    import fetch_pkg::*;
    import isa_pkg::*;
#(
    parameter addr_t reset_pc        = 32'h0000_0000,
    parameter int    len_queue_depth = 16
) (
    input  logic        clk,
    input  logic        rst,

    input  logic        stall,
    input  logic        redirect,
    input  addr_t       redirect_pc,
    input  logic        retire,

    output logic        mem_req,
    output addr_t       mem_addr,
    input  logic        mem_valid,
    input  instr_word_t mem_data,

    output logic        instr_valid,
    output instr_word_t instr,
    output addr_t       instr_pc,

    output addr_t       retire_pc
);

    addr_t       dec_pc;
    instr_word_t dec_word;
    addr_t       full_next_pc;
    logic        full_stop;
    addr_t       comp_next_pc;
    logic        comp_stop;

    // both views of the same word are decoded side by side
    full_predecode full_predecode_i (
        .pc      (dec_pc),
        .word    (dec_word),
        .next_pc (full_next_pc),
        .stop    (full_stop)
    );

    compressed_predecode compressed_predecode_i (
        .pc      (dec_pc),
        .word    (dec_word),
        .next_pc (comp_next_pc),
        .stop    (comp_stop)
    );

    fetch_unit #(
        .reset_pc        (reset_pc),
        .len_queue_depth (len_queue_depth)
    ) fetch_unit_i (
        .clk          (clk),
        .rst          (rst),
        .stall        (stall),
        .redirect     (redirect),
        .redirect_pc  (redirect_pc),
        .retire       (retire),
        .mem_req      (mem_req),
        .mem_addr     (mem_addr),
        .mem_valid    (mem_valid),
        .mem_data     (mem_data),
        .full_next_pc (full_next_pc),
        .full_stop    (full_stop),
        .comp_next_pc (comp_next_pc),
        .comp_stop    (comp_stop),
        .dec_pc       (dec_pc),
        .dec_word     (dec_word),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .instr_pc     (instr_pc),
        .retire_pc    (retire_pc)
    );

endmodule

`default_nettype wire

/* fetch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_unit
    import fetch_pkg::*;
    import isa_pkg::*;
#(
    parameter addr_t reset_pc        = 32'h0000_0000,
    parameter int    len_queue_depth = 16
) (
    input  logic        clk,
    input  logic        rst,

    input  logic        stall,
    input  logic        redirect,
    input  addr_t       redirect_pc,
    input  logic        retire,

    output logic        mem_req,
    output addr_t       mem_addr,
    input  logic        mem_valid,
    input  instr_word_t mem_data,

    input  addr_t       full_next_pc,
    input  logic        full_stop,
    input  addr_t       comp_next_pc,
    input  logic        comp_stop,
    output addr_t       dec_pc,
    output instr_word_t dec_word,

    output logic        instr_valid,
    output instr_word_t instr,
    output addr_t       instr_pc,

    output addr_t       retire_pc
);

    localparam int ptr_w = $clog2(len_queue_depth);

    // request state
    logic        started;
    logic        outstanding;
    logic        discard;
    logic        stop_pending;
    logic        waiting;
    addr_t       pred_pc;
    addr_t       fetch_pc;

    // registered response
    instr_word_t resp_word;
    addr_t       resp_pc;

    // predecoder selection
    len_t        dec_len;
    addr_t       pick_next_pc;
    logic        pick_stop;

    // length queue, pointers carry one extra wrap bit
    len_t        len_q [len_queue_depth];
    logic [ptr_w:0] q_head;
    logic [ptr_w:0] q_tail;
    logic        q_empty;
    logic        q_full;
    logic        q_push;
    logic        q_pop;

    // the instr_valid cycle still counts as outstanding, so the next request
    // comes one cycle later with the updated prediction
    assign mem_req  = started && !outstanding && !stall && !stop_pending && !redirect;
    assign mem_addr = pred_pc;

    // a request that has been sent but whose data has not come back yet
    assign waiting = outstanding && !instr_valid && !mem_valid;

    assign instr    = resp_word;
    assign instr_pc = resp_pc;
    assign dec_word = resp_word;
    assign dec_pc   = resp_pc;

    assign dec_len      = (resp_word.parcel.lower[1:0] == full_len_bits) ? len_word : len_half;
    assign pick_next_pc = (dec_len == len_word) ? full_next_pc : comp_next_pc;
    assign pick_stop    = (dec_len == len_word) ? full_stop : comp_stop;

    always_ff @(posedge clk) begin
        if (rst) begin
            started      <= 1'b0;
            outstanding  <= 1'b0;
            discard      <= 1'b0;
            stop_pending <= 1'b0;
            instr_valid  <= 1'b0;
            pred_pc      <= reset_pc;
            fetch_pc     <= reset_pc;
        end else begin
            started     <= 1'b1;
            instr_valid <= 1'b0;

            if (mem_req) begin
                outstanding <= 1'b1;
                fetch_pc    <= pred_pc;
            end

            if (mem_valid) begin
                if (discard || redirect) begin
                    // flushed fetch, the word never reaches the back end
                    outstanding <= 1'b0;
                    discard     <= 1'b0;
                end else begin
                    instr_valid <= 1'b1;
                end
            end

            if (instr_valid) begin
                outstanding  <= 1'b0;
                pred_pc      <= pick_next_pc;
                stop_pending <= pick_stop;
            end

            if (redirect) begin
                pred_pc      <= redirect_pc;
                fetch_pc     <= redirect_pc;
                stop_pending <= 1'b0;
                // the old response still has to come back before a new request goes out
                if (waiting) begin
                    discard <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mem_valid) begin
            resp_word <= mem_data;
            resp_pc   <= fetch_pc;
        end
    end

    assign q_empty = (q_head == q_tail);
    assign q_full  = (q_head[ptr_w] != q_tail[ptr_w]) &&
                     (q_head[ptr_w-1:0] == q_tail[ptr_w-1:0]);
    assign q_push  = instr_valid && !redirect && !q_full;
    assign q_pop   = retire && !redirect && !q_empty;

    always_ff @(posedge clk) begin
        if (rst) begin
            q_head    <= '0;
            q_tail    <= '0;
            retire_pc <= reset_pc;
        end else if (redirect) begin
            q_head    <= '0;
            q_tail    <= '0;
            retire_pc <= redirect_pc;
        end else begin
            if (q_push) begin
                q_tail <= q_tail + 1'b1;
            end
            if (q_pop) begin
                q_head    <= q_head + 1'b1;
                retire_pc <= retire_pc + len_bytes(len_q[q_head[ptr_w-1:0]]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (q_push) begin
            len_q[q_tail[ptr_w-1:0]] <= dec_len;
        end
    end

endmodule

`default_nettype wire

/* compressed_predecode.sv */
`timescale 1ns/1ps
`default_nettype none

module compressed_predecode
    import fetch_pkg::*;
    import isa_pkg::*;
(
    input  addr_t       pc,
    input  instr_word_t word,
    output addr_t       next_pc,
    output logic        stop
);

    logic [15:0] c;
    logic [1:0]  quadrant;
    logic [2:0]  funct3;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    addr_t       cj_imm;
    logic        is_cj;
    logic        is_cjr;

    assign c        = word.parcel.lower;
    assign quadrant = c[1:0];
    assign funct3   = c[15:13];
    assign rs1      = c[11:7];
    assign rs2      = c[6:2];

    // CJ offset bits [12:2] hold imm[11|4|9:8|10|6|7|3:1|5]
    assign cj_imm = {
        {20{c[12]}},
        c[12],
        c[8],
        c[10:9],
        c[6],
        c[7],
        c[2],
        c[11],
        c[5:3],
        1'b0
    };

    // C.JAL only exists in RV32, in RV64 the same encoding is C.ADDIW
    assign is_cj = (quadrant == c_quadrant_q1) &&
                   ((funct3 == c_funct3_j) || (funct3 == c_funct3_jal));

    // C.JR and C.JALR differ only in bit 12
    // rs2 of zero keeps C.MV and C.ADD out, rs1 of zero keeps C.EBREAK out
    assign is_cjr = (quadrant == c_quadrant_q2) &&
                    (funct3 == c_funct3_jr) &&
                    (rs1 != 5'd0) &&
                    (rs2 == 5'd0);

    always_comb begin
        next_pc = pc + 32'd2;
        stop    = 1'b0;
        if (is_cj) begin
            next_pc = pc + cj_imm;
        end else if (is_cjr) begin
            stop = 1'b1;
        end
    end

endmodule

`default_nettype wire

/* full_predecode.sv */
`timescale 1ns/1ps
`default_nettype none

module full_predecode
    import fetch_pkg::*;
    import isa_pkg::*;
(
    input  addr_t       pc,
    input  instr_word_t word,
    output addr_t       next_pc,
    output logic        stop
);

    addr_t       j_imm;
    logic [6:0]  opcode;

    assign opcode = word.full[6:0];

    // J-type immediate is imm[20|10:1|11|19:12] in bits [31:12]
    assign j_imm = {
        {11{word.full[31]}},
        word.full[31],
        word.full[19:12],
        word.full[20],
        word.full[30:21],
        1'b0
    };

    always_comb begin
        next_pc = pc + 32'd4;
        stop    = 1'b0;
        case (opcode)
            op_jal: begin
                next_pc = pc + j_imm;
            end
            op_jalr: begin
                // target depends on a register, wait for the back end to resolve it
                stop = 1'b1;
            end
            op_auipc: begin
                next_pc = pc + 32'd4;
            end
            default: begin
                // conditional branches are predicted not taken
                next_pc = pc + 32'd4;
            end
        endcase
    end

endmodule

`default_nettype wire

/* fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

    // byte address for pcs and memory requests
    typedef logic [31:0] addr_t;

    // instruction length, one bit per delivered instruction
    typedef logic len_t;

    localparam len_t len_word = 1'b1;
    localparam len_t len_half = 1'b0;

    // byte step that belongs to a length code
    function automatic addr_t len_bytes(input len_t len);
        addr_t step;
        if (len == len_word) begin
            step = 32'd4;
        end else begin
            step = 32'd2;
        end
        return step;
    endfunction

endpackage

`default_nettype wire

/* isa_pkg.sv */
`default_nettype none

package isa_pkg;

    // major opcodes in bits [6:0] of a 32-bit instruction
    localparam logic [6:0] op_jal   = 7'b1101111;
    localparam logic [6:0] op_jalr  = 7'b1100111;

    // AUIPC only builds a value from the pc, control flow goes on in order
    localparam logic [6:0] op_auipc = 7'b0010111;

    // any value other than 11 in bits [1:0] marks a 16-bit compressed parcel
    localparam logic [1:0] full_len_bits = 2'b11;

    // compressed quadrants, bits [1:0] of the parcel
    localparam logic [1:0] c_quadrant_q1 = 2'b01;
    localparam logic [1:0] c_quadrant_q2 = 2'b10;

    // compressed funct3, bits [15:13] of the parcel
    localparam logic [2:0] c_funct3_j   = 3'b101;
    localparam logic [2:0] c_funct3_jal = 3'b001;

    // shared by C.JR, C.JALR, C.MV, C.ADD and C.EBREAK
    // the rs1 and rs2 fields tell them apart
    localparam logic [2:0] c_funct3_jr  = 3'b100;

    // a fetched word split into two halfwords
    // the lower half is where a compressed instruction sits
    typedef struct packed {
        logic [15:0] upper;
        logic [15:0] lower;
    } parcel_t;

    // the same fetched word seen either as a full instruction or as two parcels
    typedef union packed {
        logic [31:0] full;
        parcel_t     parcel;
    } instr_word_t;

endpackage

`default_nettype wire
